// File: hdl/decode_stage.sv
`timescale 1ns/1ps
`default_nettype none

module decode_stage (
	input  logic                                clock,
	input  logic                                reset,
	input  rv_isa_pkg::inst_word_u              inst,
	input  logic [pipe_pkg::xlen-1:0]           pc,
	input  logic                                in_valid,
	output logic                                in_ready,
	input  logic                                flush,
	output logic [pipe_pkg::reg_idx_width-1:0]  rs1,
	output logic [pipe_pkg::reg_idx_width-1:0]  rs2,
	input  logic [pipe_pkg::xlen-1:0]           rf_rs1_data,
	input  logic [pipe_pkg::xlen-1:0]           rf_rs2_data,
	fwd_if.sink                                 exu,
	fwd_if.sink                                 lsu,
	output logic                                out_valid,
	output logic [pipe_pkg::xlen-1:0]           out_pc,
	output logic [rv_isa_pkg::class_count-1:0] out_class,
	output logic [2:0]                          out_funct3,
	output logic                                out_funct7_5,
	output logic [pipe_pkg::reg_idx_width-1:0]  out_rd,
	output logic [pipe_pkg::xlen-1:0]           out_src1,
	output logic [pipe_pkg::xlen-1:0]           out_src2,
	output logic [pipe_pkg::xlen-1:0]           out_imm,
	output logic                                out_reg_wen,
	output logic                                out_ecall,
	output logic                                out_mret,
	output logic                                out_fencei,
	input  logic                                out_ready
);

	logic [rv_isa_pkg::class_count-1:0] dec_class;
	logic [2:0]                         dec_funct3;
	logic                               dec_funct7_5;
	logic [pipe_pkg::reg_idx_width-1:0] dec_rd;
	logic [pipe_pkg::xlen-1:0]          dec_imm;
	logic                               dec_reg_wen;
	logic                               need_rs1;
	logic                               need_rs2;
	logic                               dec_ecall;
	logic                               dec_mret;
	logic                               dec_fencei;
	logic [pipe_pkg::xlen-1:0]          src1;
	logic [pipe_pkg::xlen-1:0]          src2;
	logic                               stall;
	logic                               accept;

	inst_decoder dec_i (
		.inst       (inst),
		.inst_class (dec_class),
		.funct3     (dec_funct3),
		.funct7_5   (dec_funct7_5),
		.rd         (dec_rd),
		.rs1        (rs1),
		.rs2        (rs2),
		.imm        (dec_imm),
		.reg_wen    (dec_reg_wen),
		.need_rs1   (need_rs1),
		.need_rs2   (need_rs2),
		.is_ecall   (dec_ecall),
		.is_mret    (dec_mret),
		.is_fencei  (dec_fencei)
	);

	hazard_bypass byp_i (
		.rs1         (rs1),
		.rs2         (rs2),
		.need_rs1    (need_rs1),
		.need_rs2    (need_rs2),
		.rf_rs1_data (rf_rs1_data),
		.rf_rs2_data (rf_rs2_data),
		.exu         (exu),
		.lsu         (lsu),
		.src1        (src1),
		.src2        (src2),
		.stall       (stall)
	);

	// slot free or draining this cycle
	assign in_ready = (~out_valid | out_ready) & ~stall & ~flush;
	assign accept   = in_valid & in_ready;

	always_ff @(posedge clock) begin
		if (reset || flush)
			out_valid <= 1'b0;
		else if (accept)
			out_valid <= 1'b1;
		else if (out_ready)
			out_valid <= 1'b0;
	end

	always_ff @(posedge clock) begin
		if (accept) begin
			out_pc       <= pc;
			out_class    <= dec_class;
			out_funct3   <= dec_funct3;
			out_funct7_5 <= dec_funct7_5;
			out_rd       <= dec_rd;
			out_src1     <= src1;
			out_src2     <= src2;
			out_imm      <= dec_imm;
			out_reg_wen  <= dec_reg_wen;
			out_ecall    <= dec_ecall;
			out_mret     <= dec_mret;
			out_fencei   <= dec_fencei;
		end
	end

endmodule

`default_nettype wire

// File: hdl/decode_top.sv
`timescale 1ns/1ps
`default_nettype none

module decode_top (
	input  logic                                clock,
	input  logic                                reset,
	input  logic [31:0]                         inst,
	input  logic [pipe_pkg::xlen-1:0]           pc,
	input  logic                                in_valid,
	output logic                                in_ready,
	input  logic                                flush,
	input  logic                                exu_busy,
	input  logic [pipe_pkg::reg_idx_width-1:0]  exu_rd,
	input  logic                                exu_reg_wen,
	input  logic                                exu_is_load,
	input  logic [pipe_pkg::xlen-1:0]           exu_value,
	input  logic                                lsu_busy,
	input  logic [pipe_pkg::reg_idx_width-1:0]  lsu_rd,
	input  logic                                lsu_reg_wen,
	input  logic                                lsu_is_load,
	input  logic [pipe_pkg::xlen-1:0]           lsu_value,
	input  logic                                wb_en,
	input  logic [pipe_pkg::reg_idx_width-1:0]  wb_rd,
	input  logic [pipe_pkg::xlen-1:0]           wb_data,
	output logic                                out_valid,
	output logic [pipe_pkg::xlen-1:0]           out_pc,
	output logic [rv_isa_pkg::class_count-1:0] out_class,
	output logic [2:0]                          out_funct3,
	output logic                                out_funct7_5,
	output logic [pipe_pkg::reg_idx_width-1:0]  out_rd,
	output logic [pipe_pkg::xlen-1:0]           out_src1,
	output logic [pipe_pkg::xlen-1:0]           out_src2,
	output logic [pipe_pkg::xlen-1:0]           out_imm,
	output logic                                out_reg_wen,
	output logic                                out_ecall,
	output logic                                out_mret,
	output logic                                out_fencei,
	input  logic                                out_ready
);

	logic [pipe_pkg::reg_idx_width-1:0] rs1;
	logic [pipe_pkg::reg_idx_width-1:0] rs2;
	logic [pipe_pkg::xlen-1:0]          rs1_data;
	logic [pipe_pkg::xlen-1:0]          rs2_data;

	fwd_if exu_fwd ();
	fwd_if lsu_fwd ();

	assign exu_fwd.busy    = exu_busy;
	assign exu_fwd.rd      = exu_rd;
	assign exu_fwd.reg_wen = exu_reg_wen;
	assign exu_fwd.is_load = exu_is_load;
	assign exu_fwd.value   = exu_value;

	assign lsu_fwd.busy    = lsu_busy;
	assign lsu_fwd.rd      = lsu_rd;
	assign lsu_fwd.reg_wen = lsu_reg_wen;
	assign lsu_fwd.is_load = lsu_is_load;
	assign lsu_fwd.value   = lsu_value;

	reg_file rf_i (
		.clock    (clock),
		.reset    (reset),
		.rs1      (rs1),
		.rs2      (rs2),
		.rs1_data (rs1_data),
		.rs2_data (rs2_data),
		.wr_en    (wb_en),
		.wr_idx   (wb_rd),
		.wr_data  (wb_data)
	);

	decode_stage stage_i (
		.clock        (clock),
		.reset        (reset),
		.inst         (inst),
		.pc           (pc),
		.in_valid     (in_valid),
		.in_ready     (in_ready),
		.flush        (flush),
		.rs1          (rs1),
		.rs2          (rs2),
		.rf_rs1_data  (rs1_data),
		.rf_rs2_data  (rs2_data),
		.exu          (exu_fwd),
		.lsu          (lsu_fwd),
		.out_valid    (out_valid),
		.out_pc       (out_pc),
		.out_class    (out_class),
		.out_funct3   (out_funct3),
		.out_funct7_5 (out_funct7_5),
		.out_rd       (out_rd),
		.out_src1     (out_src1),
		.out_src2     (out_src2),
		.out_imm      (out_imm),
		.out_reg_wen  (out_reg_wen),
		.out_ecall    (out_ecall),
		.out_mret     (out_mret),
		.out_fencei   (out_fencei),
		.out_ready    (out_ready)
	);

endmodule

`default_nettype wire

// File: hdl/fwd_if.sv
`timescale 1ns/1ps
`default_nettype none

// destination info of one instruction still in flight downstream
interface fwd_if;

	logic                              busy;
	logic [pipe_pkg::reg_idx_width-1:0] rd;
	logic                              reg_wen;
	logic                              is_load; // value not ready yet
	logic [pipe_pkg::xlen-1:0]          value;

	modport source (output busy, rd, reg_wen, is_load, value);
	modport sink   (input busy, rd, reg_wen, is_load, value);

endinterface

`default_nettype wire

// File: hdl/hazard_bypass.sv
`timescale 1ns/1ps
`default_nettype none

module hazard_bypass (
	input  logic [pipe_pkg::reg_idx_width-1:0] rs1,
	input  logic [pipe_pkg::reg_idx_width-1:0] rs2,
	input  logic                               need_rs1,
	input  logic                               need_rs2,
	input  logic [pipe_pkg::xlen-1:0]          rf_rs1_data,
	input  logic [pipe_pkg::xlen-1:0]          rf_rs2_data,
	fwd_if.sink                                exu,
	fwd_if.sink                                lsu,
	output logic [pipe_pkg::xlen-1:0]          src1,
	output logic [pipe_pkg::xlen-1:0]          src2,
	output logic                               stall
);

	logic exu_hit1;
	logic exu_hit2;
	logic lsu_hit1;
	logic lsu_hit2;

	// x0 never matches
	function automatic logic src_hit(
		input logic                               busy,
		input logic                               wen,
		input logic [pipe_pkg::reg_idx_width-1:0] dst,
		input logic [pipe_pkg::reg_idx_width-1:0] src,
		input logic                               need
	);
		return busy & wen & need & (dst == src) & (src != '0);
	endfunction

	assign exu_hit1 = src_hit(exu.busy, exu.reg_wen, exu.rd, rs1, need_rs1);
	assign exu_hit2 = src_hit(exu.busy, exu.reg_wen, exu.rd, rs2, need_rs2);
	assign lsu_hit1 = src_hit(lsu.busy, lsu.reg_wen, lsu.rd, rs1, need_rs1);
	assign lsu_hit2 = src_hit(lsu.busy, lsu.reg_wen, lsu.rd, rs2, need_rs2);

	// execute is younger, so it wins
	assign src1 = exu_hit1 ? exu.value :
		lsu_hit1 ? lsu.value : rf_rs1_data;
	assign src2 = exu_hit2 ? exu.value :
		lsu_hit2 ? lsu.value : rf_rs2_data;

	assign stall = (exu.is_load & (exu_hit1 | exu_hit2)) |
		(lsu.is_load & (lsu_hit1 | lsu_hit2)); // load-use

endmodule

`default_nettype wire

// File: hdl/inst_decoder.sv
`timescale 1ns/1ps
`default_nettype none

module inst_decoder (
	input  rv_isa_pkg::inst_word_u              inst,
	output logic [rv_isa_pkg::class_count-1:0] inst_class,
	output logic [2:0]                          funct3,
	output logic                                funct7_5,
	output logic [pipe_pkg::reg_idx_width-1:0]  rd,
	output logic [pipe_pkg::reg_idx_width-1:0]  rs1,
	output logic [pipe_pkg::reg_idx_width-1:0]  rs2,
	output logic [pipe_pkg::xlen-1:0]           imm,
	output logic                                reg_wen,
	output logic                                need_rs1,
	output logic                                need_rs2,
	output logic                                is_ecall,
	output logic                                is_mret,
	output logic                                is_fencei
);

	logic [6:0]                       opcode;
	logic [rv_isa_pkg::fmt_count-1:0] fmt;

	assign opcode = inst.r_fmt.opcode;

	assign inst_class[rv_isa_pkg::cls_lui]    = (opcode == rv_isa_pkg::op_lui);
	assign inst_class[rv_isa_pkg::cls_auipc]  = (opcode == rv_isa_pkg::op_auipc);
	assign inst_class[rv_isa_pkg::cls_jal]    = (opcode == rv_isa_pkg::op_jal);
	assign inst_class[rv_isa_pkg::cls_jalr]   = (opcode == rv_isa_pkg::op_jalr);
	assign inst_class[rv_isa_pkg::cls_beq]    = (opcode == rv_isa_pkg::op_branch);
	assign inst_class[rv_isa_pkg::cls_lw]     = (opcode == rv_isa_pkg::op_load);
	assign inst_class[rv_isa_pkg::cls_sw]     = (opcode == rv_isa_pkg::op_store);
	assign inst_class[rv_isa_pkg::cls_addi]   = (opcode == rv_isa_pkg::op_imm);
	assign inst_class[rv_isa_pkg::cls_add]    = (opcode == rv_isa_pkg::op_reg);
	assign inst_class[rv_isa_pkg::cls_system] = (opcode == rv_isa_pkg::op_system);

	// format follows from the class
	assign fmt[rv_isa_pkg::fmt_r] = inst_class[rv_isa_pkg::cls_add];
	assign fmt[rv_isa_pkg::fmt_i] = inst_class[rv_isa_pkg::cls_jalr] |
		inst_class[rv_isa_pkg::cls_lw] | inst_class[rv_isa_pkg::cls_addi] |
		inst_class[rv_isa_pkg::cls_system];
	assign fmt[rv_isa_pkg::fmt_s] = inst_class[rv_isa_pkg::cls_sw];
	assign fmt[rv_isa_pkg::fmt_b] = inst_class[rv_isa_pkg::cls_beq];
	assign fmt[rv_isa_pkg::fmt_u] = inst_class[rv_isa_pkg::cls_lui] |
		inst_class[rv_isa_pkg::cls_auipc];
	assign fmt[rv_isa_pkg::fmt_j] = inst_class[rv_isa_pkg::cls_jal];

	assign funct3   = inst.r_fmt.funct3;
	assign funct7_5 = inst.r_fmt.funct7[5];
	assign rd       = inst.r_fmt.rd[pipe_pkg::reg_idx_width-1:0];
	assign rs1      = inst.r_fmt.rs1[pipe_pkg::reg_idx_width-1:0];
	assign rs2      = inst.r_fmt.rs2[pipe_pkg::reg_idx_width-1:0];

	always_comb begin
		imm = '0; // r format and unknown opcodes
		if (fmt[rv_isa_pkg::fmt_i])
			imm = {{20{inst.i_fmt.imm_11_0[11]}}, inst.i_fmt.imm_11_0};
		else if (fmt[rv_isa_pkg::fmt_u])
			imm = {inst.u_fmt.imm_31_12, 12'b0};
		else if (fmt[rv_isa_pkg::fmt_s])
			imm = {{20{inst.s_fmt.imm_11_5[6]}}, inst.s_fmt.imm_11_5, inst.s_fmt.imm_4_0};
		else if (fmt[rv_isa_pkg::fmt_j])
			imm = {{12{inst.j_fmt.imm_20}}, inst.j_fmt.imm_19_12, inst.j_fmt.imm_11,
				inst.j_fmt.imm_10_1, 1'b0};
		else if (fmt[rv_isa_pkg::fmt_b])
			imm = {{20{inst.b_fmt.imm_12}}, inst.b_fmt.imm_11, inst.b_fmt.imm_10_5,
				inst.b_fmt.imm_4_1, 1'b0};
	end

	// csr ops with funct3 zero (ecall, mret) write no register
	assign reg_wen = fmt[rv_isa_pkg::fmt_r] | fmt[rv_isa_pkg::fmt_u] | fmt[rv_isa_pkg::fmt_j] |
		(fmt[rv_isa_pkg::fmt_i] & ~(inst_class[rv_isa_pkg::cls_system] & (funct3 == 3'b000)));

	assign need_rs2 = inst_class[rv_isa_pkg::cls_beq] | inst_class[rv_isa_pkg::cls_sw] |
		inst_class[rv_isa_pkg::cls_add];
	assign need_rs1 = need_rs2 | fmt[rv_isa_pkg::fmt_i];

	assign is_ecall  = (inst == rv_isa_pkg::inst_ecall_word);
	assign is_mret   = (inst == rv_isa_pkg::inst_mret_word);
	assign is_fencei = (opcode == rv_isa_pkg::op_fence);

endmodule

`default_nettype wire

// File: hdl/pipe_pkg.sv
`default_nettype none

package pipe_pkg;

	localparam int xlen          = 32;
	localparam int reg_count     = 16; // rv32e
	localparam int reg_idx_width = 4;  // low bits of the 5-bit fields

endpackage

`default_nettype wire

// File: hdl/reg_file.sv
`timescale 1ns/1ps
`default_nettype none

module reg_file (
	input  logic                               clock,
	input  logic                               reset,
	input  logic [pipe_pkg::reg_idx_width-1:0] rs1,
	input  logic [pipe_pkg::reg_idx_width-1:0] rs2,
	output logic [pipe_pkg::xlen-1:0]          rs1_data,
	output logic [pipe_pkg::xlen-1:0]          rs2_data,
	input  logic                               wr_en,
	input  logic [pipe_pkg::reg_idx_width-1:0] wr_idx,
	input  logic [pipe_pkg::xlen-1:0]          wr_data
);

	logic [pipe_pkg::xlen-1:0] regs [pipe_pkg::reg_count];

	always_ff @(posedge clock) begin
		if (reset) begin
			for (int i = 0; i < pipe_pkg::reg_count; i++)
				regs[i] <= '0;
		end else if (wr_en && wr_idx != '0) begin
			regs[wr_idx] <= wr_data;
		end
	end

	assign rs1_data = (rs1 == '0) ? '0 : regs[rs1]; // x0 hardwired
	assign rs2_data = (rs2 == '0) ? '0 : regs[rs2];

endmodule

`default_nettype wire

// File: hdl/rv_isa_pkg.sv
`default_nettype none

package rv_isa_pkg;

	// major opcodes
	localparam logic [6:0] op_lui    = 7'b0110111;
	localparam logic [6:0] op_auipc  = 7'b0010111;
	localparam logic [6:0] op_jal    = 7'b1101111;
	localparam logic [6:0] op_jalr   = 7'b1100111;
	localparam logic [6:0] op_branch = 7'b1100011;
	localparam logic [6:0] op_load   = 7'b0000011;
	localparam logic [6:0] op_store  = 7'b0100011;
	localparam logic [6:0] op_imm    = 7'b0010011;
	localparam logic [6:0] op_reg    = 7'b0110011;
	localparam logic [6:0] op_system = 7'b1110011;
	localparam logic [6:0] op_fence  = 7'b0001111; // only fence.i is flagged

	// one-hot class positions
	localparam int cls_lui     = 0;
	localparam int cls_auipc   = 1;
	localparam int cls_jal     = 2;
	localparam int cls_jalr    = 3;
	localparam int cls_beq     = 4;
	localparam int cls_lw      = 5;
	localparam int cls_sw      = 6;
	localparam int cls_addi    = 7;
	localparam int cls_add     = 8;
	localparam int cls_system  = 9;
	localparam int class_count = 10;

	// immediate formats
	localparam int fmt_r     = 0;
	localparam int fmt_i     = 1;
	localparam int fmt_s     = 2;
	localparam int fmt_b     = 3;
	localparam int fmt_u     = 4;
	localparam int fmt_j     = 5;
	localparam int fmt_count = 6;

	localparam logic [31:0] inst_ecall_word = 32'h0000_0073;
	localparam logic [31:0] inst_mret_word  = 32'h3020_0073;

	// one instruction word, seen through each format
	typedef union packed {
		struct packed {
			logic [6:0] funct7;
			logic [4:0] rs2;
			logic [4:0] rs1;
			logic [2:0] funct3;
			logic [4:0] rd;
			logic [6:0] opcode;
		} r_fmt;
		struct packed {
			logic [11:0] imm_11_0;
			logic [4:0]  rs1;
			logic [2:0]  funct3;
			logic [4:0]  rd;
			logic [6:0]  opcode;
		} i_fmt;
		struct packed {
			logic [6:0] imm_11_5;
			logic [4:0] rs2;
			logic [4:0] rs1;
			logic [2:0] funct3;
			logic [4:0] imm_4_0;
			logic [6:0] opcode;
		} s_fmt;
		struct packed {
			logic       imm_12;
			logic [5:0] imm_10_5;
			logic [4:0] rs2;
			logic [4:0] rs1;
			logic [2:0] funct3;
			logic [3:0] imm_4_1;
			logic       imm_11;
			logic [6:0] opcode;
		} b_fmt;
		struct packed {
			logic [19:0] imm_31_12;
			logic [4:0]  rd;
			logic [6:0]  opcode;
		} u_fmt;
		struct packed {
			logic       imm_20;
			logic [9:0] imm_10_1;
			logic       imm_11;
			logic [7:0] imm_19_12;
			logic [4:0] rd;
			logic [6:0] opcode;
		} j_fmt;
	} inst_word_u;

endpackage

`default_nettype wire

// File: tb/rv_encode.svh
`ifndef RV_ENCODE_SVH
`define RV_ENCODE_SVH

// encoders, one per instruction format
function automatic logic [31:0] enc_r(input logic [6:0] funct7, input logic [4:0] rs2,
		input logic [4:0] rs1, input logic [2:0] funct3, input logic [4:0] rd,
		input logic [6:0] opcode);
	return {funct7, rs2, rs1, funct3, rd, opcode};
endfunction

function automatic logic [31:0] enc_i(input logic [11:0] imm, input logic [4:0] rs1,
		input logic [2:0] funct3, input logic [4:0] rd, input logic [6:0] opcode);
	return {imm, rs1, funct3, rd, opcode};
endfunction

function automatic logic [31:0] enc_s(input logic [11:0] imm, input logic [4:0] rs2,
		input logic [4:0] rs1, input logic [2:0] funct3, input logic [6:0] opcode);
	return {imm[11:5], rs2, rs1, funct3, imm[4:0], opcode};
endfunction

function automatic logic [31:0] enc_b(input logic [12:0] imm, input logic [4:0] rs2,
		input logic [4:0] rs1, input logic [2:0] funct3, input logic [6:0] opcode);
	return {imm[12], imm[10:5], rs2, rs1, funct3, imm[4:1], imm[11], opcode};
endfunction

function automatic logic [31:0] enc_u(input logic [19:0] imm, input logic [4:0] rd,
		input logic [6:0] opcode);
	return {imm, rd, opcode};
endfunction

function automatic logic [31:0] enc_j(input logic [20:0] imm, input logic [4:0] rd,
		input logic [6:0] opcode);
	return {imm[20], imm[10:1], imm[11], imm[19:12], rd, opcode};
endfunction

// sign extension of a field that is width bits wide
function automatic logic [31:0] sext(input logic [31:0] value, input int width);
	logic [31:0] upper;
	upper = 32'hffff_ffff << width;
	return value[width-1] ? (value | upper) : (value & ~upper);
endfunction

`endif

// File: tb/decode_tb.sv
`timescale 1ns/1ps
`default_nettype none

module decode_tb;

	`include "rv_encode.svh"

	localparam int cycle_limit = 3000;

	typedef struct packed {
		logic [31:0] pc;
		logic [9:0]  cls;
		logic [2:0]  funct3;
		logic        funct7_5;
		logic [3:0]  rd;
		logic [31:0] src1;
		logic [31:0] src2;
		logic [31:0] imm;
		logic        reg_wen;
		logic        ecall;
		logic        mret;
		logic        fencei;
	} bundle_t;

	logic        clock = 1'b0;
	logic        reset;
	logic [31:0] inst;
	logic [31:0] pc;
	logic        in_valid;
	logic        in_ready;
	logic        flush;
	logic        exu_busy;
	logic [3:0]  exu_rd;
	logic        exu_reg_wen;
	logic        exu_is_load;
	logic [31:0] exu_value;
	logic        lsu_busy;
	logic [3:0]  lsu_rd;
	logic        lsu_reg_wen;
	logic        lsu_is_load;
	logic [31:0] lsu_value;
	logic        wb_en;
	logic [3:0]  wb_rd;
	logic [31:0] wb_data;
	logic        out_valid;
	logic [31:0] out_pc;
	logic [9:0]  out_class;
	logic [2:0]  out_funct3;
	logic        out_funct7_5;
	logic [3:0]  out_rd;
	logic [31:0] out_src1;
	logic [31:0] out_src2;
	logic [31:0] out_imm;
	logic        out_reg_wen;
	logic        out_ecall;
	logic        out_mret;
	logic        out_fencei;
	logic        out_ready;

	// reference model state
	bundle_t     exp_q[$];
	bundle_t     exp_head;
	logic        exp_pending;
	logic        exp_in_ready;
	logic        last_accept;
	logic [31:0] shadow [16];
	int          cycles = 0;
	int          delivered = 0;
	int          sent;

	// what the instruction on the input port is
	int          cur_cls; // -1 for fence.i
	logic [31:0] cur_imm;
	logic        cur_ecall;
	logic        cur_mret;
	logic        cur_fencei;

	decode_top dut_i (.*);

	always #5 clock = ~clock;

	task automatic abort_run(input string why);
		$display("%s", why);
		$display(">>> FAIL");
		$fatal(1, "run stopped at the first error");
	endtask

	task automatic value_error(input string name, input logic [31:0] exp, input logic [31:0] act);
		abort_run($sformatf("mismatch at %0t ns: %s expected %h got %h", $time, name, exp, act));
	endtask

	always @(posedge clock) begin
		cycles++;
		if (cycles >= cycle_limit)
			abort_run("timeout: the run did not finish within the cycle limit");
	end

	valid_chk: assert property (@(posedge clock) disable iff (reset)
		out_valid == exp_pending)
		else value_error("out_valid", $sampled(exp_pending), $sampled(out_valid));
	ready_chk: assert property (@(posedge clock) disable iff (reset)
		in_ready == exp_in_ready)
		else value_error("in_ready", $sampled(exp_in_ready), $sampled(in_ready));
	pc_chk: assert property (@(posedge clock) disable iff (reset)
		out_valid |-> out_pc == exp_head.pc)
		else value_error("out_pc", $sampled(exp_head.pc), $sampled(out_pc));
	class_chk: assert property (@(posedge clock) disable iff (reset)
		out_valid |-> out_class == exp_head.cls)
		else value_error("out_class", $sampled(exp_head.cls), $sampled(out_class));
	funct3_chk: assert property (@(posedge clock) disable iff (reset)
		out_valid |-> out_funct3 == exp_head.funct3)
		else value_error("out_funct3", $sampled(exp_head.funct3), $sampled(out_funct3));
	funct7_chk: assert property (@(posedge clock) disable iff (reset)
		out_valid |-> out_funct7_5 == exp_head.funct7_5)
		else value_error("out_funct7_5", $sampled(exp_head.funct7_5), $sampled(out_funct7_5));
	rd_chk: assert property (@(posedge clock) disable iff (reset)
		out_valid |-> out_rd == exp_head.rd)
		else value_error("out_rd", $sampled(exp_head.rd), $sampled(out_rd));
	src1_chk: assert property (@(posedge clock) disable iff (reset)
		out_valid |-> out_src1 == exp_head.src1)
		else value_error("out_src1", $sampled(exp_head.src1), $sampled(out_src1));
	src2_chk: assert property (@(posedge clock) disable iff (reset)
		out_valid |-> out_src2 == exp_head.src2)
		else value_error("out_src2", $sampled(exp_head.src2), $sampled(out_src2));
	imm_chk: assert property (@(posedge clock) disable iff (reset)
		out_valid |-> out_imm == exp_head.imm)
		else value_error("out_imm", $sampled(exp_head.imm), $sampled(out_imm));
	wen_chk: assert property (@(posedge clock) disable iff (reset)
		out_valid |-> out_reg_wen == exp_head.reg_wen)
		else value_error("out_reg_wen", $sampled(exp_head.reg_wen), $sampled(out_reg_wen));
	ecall_chk: assert property (@(posedge clock) disable iff (reset)
		out_valid |-> out_ecall == exp_head.ecall)
		else value_error("out_ecall", $sampled(exp_head.ecall), $sampled(out_ecall));
	mret_chk: assert property (@(posedge clock) disable iff (reset)
		out_valid |-> out_mret == exp_head.mret)
		else value_error("out_mret", $sampled(exp_head.mret), $sampled(out_mret));
	fencei_chk: assert property (@(posedge clock) disable iff (reset)
		out_valid |-> out_fencei == exp_head.fencei)
		else value_error("out_fencei", $sampled(exp_head.fencei), $sampled(out_fencei));

	function automatic logic [4:0] pick_reg();
		logic [31:0] r;
		r = $urandom;
		return r[4:0]; // bit 4 is dropped by rv32e
	endfunction

	function automatic logic uses_rs2();
		return cur_cls inside {rv_isa_pkg::cls_beq, rv_isa_pkg::cls_sw, rv_isa_pkg::cls_add};
	endfunction

	function automatic logic uses_rs1();
		return uses_rs2() || (cur_cls inside {rv_isa_pkg::cls_jalr, rv_isa_pkg::cls_lw,
			rv_isa_pkg::cls_addi, rv_isa_pkg::cls_system});
	endfunction

	// execute first, then memory, then the register file
	function automatic logic [31:0] operand(input logic [3:0] idx, input logic need);
		if (need && idx != 0 && exu_busy && exu_reg_wen && exu_rd == idx)
			return exu_value;
		if (need && idx != 0 && lsu_busy && lsu_reg_wen && lsu_rd == idx)
			return lsu_value;
		return shadow[idx];
	endfunction

	function automatic logic waits_on_load(input logic [3:0] idx, input logic need);
		if (!need || idx == 0)
			return 1'b0;
		return (exu_busy && exu_reg_wen && exu_rd == idx && exu_is_load) ||
			(lsu_busy && lsu_reg_wen && lsu_rd == idx && lsu_is_load);
	endfunction

	function automatic bundle_t predict();
		bundle_t b;
		b.pc       = pc;
		b.cls      = (cur_cls < 0) ? 10'b0 : (10'b1 << cur_cls);
		b.funct3   = inst[14:12];
		b.funct7_5 = inst[30];
		b.rd       = inst[10:7];
		b.src1     = operand(inst[18:15], uses_rs1());
		b.src2     = operand(inst[23:20], uses_rs2());
		b.imm      = cur_imm;
		b.reg_wen  = (cur_cls inside {rv_isa_pkg::cls_lui, rv_isa_pkg::cls_auipc,
			rv_isa_pkg::cls_jal, rv_isa_pkg::cls_jalr, rv_isa_pkg::cls_lw,
			rv_isa_pkg::cls_addi, rv_isa_pkg::cls_add}) ||
			(cur_cls == rv_isa_pkg::cls_system && inst[14:12] != 3'b000);
		b.ecall    = cur_ecall;
		b.mret     = cur_mret;
		b.fencei   = cur_fencei;
		return b;
	endfunction

	// kinds 0 to 9 are the classes, 10 ecall, 11 mret, 12 fence.i
	task automatic gen_inst(input int kind);
		logic [4:0]  rd;
		logic [4:0]  rs1;
		logic [4:0]  rs2;
		logic [31:0] r;
		rd = pick_reg();
		rs1 = pick_reg();
		rs2 = pick_reg();
		r = $urandom;
		cur_cls = kind;
		case (kind)
			0: begin
				inst = enc_u(r[19:0], rd, rv_isa_pkg::op_lui);
				cur_imm = {r[19:0], 12'b0};
			end
			1: begin
				inst = enc_u(r[19:0], rd, rv_isa_pkg::op_auipc);
				cur_imm = {r[19:0], 12'b0};
			end
			2: begin
				inst = enc_j({r[20:1], 1'b0}, rd, rv_isa_pkg::op_jal);
				cur_imm = sext({r[20:1], 1'b0}, 21);
			end
			3: begin
				inst = enc_i(r[11:0], rs1, 3'b000, rd, rv_isa_pkg::op_jalr);
				cur_imm = sext(r[11:0], 12);
			end
			4: begin
				inst = enc_b({r[12:1], 1'b0}, rs2, rs1, 3'b000, rv_isa_pkg::op_branch);
				cur_imm = sext({r[12:1], 1'b0}, 13);
			end
			5: begin
				inst = enc_i(r[11:0], rs1, 3'b010, rd, rv_isa_pkg::op_load);
				cur_imm = sext(r[11:0], 12);
			end
			6: begin
				inst = enc_s(r[11:0], rs2, rs1, 3'b010, rv_isa_pkg::op_store);
				cur_imm = sext(r[11:0], 12);
			end
			7: begin
				inst = enc_i(r[11:0], rs1, 3'b000, rd, rv_isa_pkg::op_imm);
				cur_imm = sext(r[11:0], 12);
			end
			8: begin
				inst = enc_r({1'b0, r[20], 5'b0}, rs2, rs1, 3'b000, rd, rv_isa_pkg::op_reg);
				cur_imm = '0; // sub when funct7 bit 5 is set
			end
			9: begin
				inst = enc_i(r[11:0], rs1, r[14:12], rd, rv_isa_pkg::op_system);
				cur_imm = sext(r[11:0], 12);
			end
			10: begin
				inst = enc_i(12'h000, 5'd0, 3'b000, 5'd0, rv_isa_pkg::op_system);
				cur_cls = rv_isa_pkg::cls_system;
				cur_imm = '0;
			end
			11: begin
				inst = enc_i(12'h302, 5'd0, 3'b000, 5'd0, rv_isa_pkg::op_system);
				cur_cls = rv_isa_pkg::cls_system;
				cur_imm = 32'h302;
			end
			default: begin
				inst = enc_i(12'h000, 5'd0, 3'b001, 5'd0, rv_isa_pkg::op_fence);
				cur_cls = -1;
				cur_imm = '0;
			end
		endcase
		// flags come from exact encodings, whatever the kind
		cur_ecall = (inst == enc_i(12'h000, 5'd0, 3'b000, 5'd0, rv_isa_pkg::op_system));
		cur_mret = (inst == enc_i(12'h302, 5'd0, 3'b000, 5'd0, rv_isa_pkg::op_system));
		cur_fencei = (inst[6:0] == rv_isa_pkg::op_fence);
	endtask

	// one clock cycle of the model, returns 1 ns after the edge
	task automatic step();
		bundle_t b;
		logic    consume;
		exp_in_ready = (!exp_pending || out_ready) && !flush &&
			!waits_on_load(inst[18:15], uses_rs1()) && !waits_on_load(inst[23:20], uses_rs2());
		last_accept = in_valid && exp_in_ready;
		consume = exp_pending && out_ready;
		if (last_accept)
			b = predict(); // registers as they were before this edge
		@(posedge clock);
		#1;
		if (wb_en && wb_rd != 0)
			shadow[wb_rd] = wb_data;
		if (flush) begin
			exp_q.delete();
		end else begin
			if (consume) begin
				void'(exp_q.pop_front());
				delivered++;
			end
			if (last_accept)
				exp_q.push_back(b);
		end
		exp_pending = (exp_q.size() != 0);
		if (exp_pending)
			exp_head = exp_q[0];
	endtask

	task automatic present(input int kind);
		gen_inst(kind);
		pc = $urandom & 32'hffff_fffc;
		in_valid = 1'b1;
	endtask

	task automatic wait_accept();
		do
			step();
		while (!last_accept);
		in_valid = 1'b0;
	endtask

	task automatic send_add(input logic [4:0] a, input logic [4:0] b);
		present(rv_isa_pkg::cls_add);
		inst[19:15] = a;
		inst[24:20] = b;
		wait_accept();
	endtask

	task automatic shake_side();
		logic [31:0] r;
		r = $urandom;
		exu_busy = r[0];
		exu_rd = {r[30], r[3:1]};
		exu_reg_wen = r[4] | r[5];
		exu_is_load = (r[8:6] == 3'b000);
		exu_value = $urandom;
		lsu_busy = r[9];
		lsu_rd = {r[31], r[12:10]};
		lsu_reg_wen = r[13] | r[14];
		lsu_is_load = (r[17:15] == 3'b000);
		lsu_value = $urandom;
		wb_en = r[18];
		wb_rd = r[22:19];
		wb_data = $urandom;
		out_ready = (r[24:23] != 2'b00);
		flush = (r[29:25] == 5'b00000);
	endtask

	initial begin
		void'($urandom(76));
		reset = 1'b1;
		in_valid = 1'b0;
		flush = 1'b0;
		out_ready = 1'b1;
		{exu_busy, exu_rd, exu_reg_wen, exu_is_load, exu_value} = '0;
		{lsu_busy, lsu_rd, lsu_reg_wen, lsu_is_load, lsu_value} = '0;
		{wb_en, wb_rd, wb_data} = '0;
		pc = '0;
		for (int i = 0; i < 16; i++)
			shadow[i] = '0;
		exp_pending = 1'b0;
		exp_in_ready = 1'b1;
		last_accept = 1'b0;
		gen_inst(rv_isa_pkg::cls_addi);
		repeat (5) @(posedge clock);
		#1;
		reset = 1'b0;

		for (int i = 1; i < 16; i++) begin
			wb_en = 1'b1;
			wb_rd = i;
			wb_data = $urandom;
			step();
		end
		wb_en = 1'b0;

		// every kind once, back to back
		for (int k = 0; k < 13; k++) begin
			present(k);
			wait_accept();
		end

		exu_busy = 1'b1;
		exu_rd = 4'd3;
		exu_reg_wen = 1'b1;
		exu_value = $urandom;
		lsu_busy = 1'b1;
		lsu_rd = 4'd3;
		lsu_reg_wen = 1'b1;
		lsu_value = $urandom;
		send_add(5'd3, 5'd3);
		exu_busy = 1'b0;
		send_add(5'd3, 5'd3);
		exu_busy = 1'b1;
		exu_reg_wen = 1'b0;
		send_add(5'd3, 5'd3);
		lsu_busy = 1'b0;
		send_add(5'd3, 5'd3);
		exu_reg_wen = 1'b1;
		exu_rd = 4'd0;
		lsu_busy = 1'b1;
		lsu_rd = 4'd0;
		send_add(5'd0, 5'd0);

		// load-use on rs1
		lsu_busy = 1'b0;
		exu_rd = 4'd5;
		exu_is_load = 1'b1;
		present(rv_isa_pkg::cls_add);
		inst[19:15] = 5'd5;
		repeat (3) step();
		exu_busy = 1'b0;
		wait_accept();

		// back-pressure
		present(rv_isa_pkg::cls_addi);
		wait_accept();
		out_ready = 1'b0;
		present(rv_isa_pkg::cls_lw);
		repeat (4) step();
		out_ready = 1'b1;
		wait_accept();

		// flush drops the held bundle
		present(rv_isa_pkg::cls_sw);
		wait_accept();
		out_ready = 1'b0;
		present(rv_isa_pkg::cls_jal);
		flush = 1'b1;
		step();
		flush = 1'b0;
		out_ready = 1'b1;
		wait_accept();

		sent = 0;
		while (sent < 250) begin
			shake_side();
			if (!in_valid || last_accept) begin
				gen_inst($urandom_range(0, 12));
				pc = $urandom & 32'hffff_fffc;
				in_valid = ($urandom_range(0, 7) != 0);
			end
			step();
			if (last_accept)
				sent++;
		end

		in_valid = 1'b0;
		flush = 1'b0;
		out_ready = 1'b1;
		exu_busy = 1'b0;
		lsu_busy = 1'b0;
		wb_en = 1'b0;
		step();
		step();
		if (delivered < 200) begin
			abort_run("too few decoded bundles were delivered");
		end else begin
			$display(">>> PASS");
			$finish;
		end
	end

endmodule

`default_nettype wire

// File: vlog.f
+incdir+tb
hdl/rv_isa_pkg.sv
hdl/pipe_pkg.sv
hdl/fwd_if.sv
hdl/inst_decoder.sv
hdl/hazard_bypass.sv
hdl/reg_file.sv
hdl/decode_stage.sv
hdl/decode_top.sv
tb/decode_tb.sv
